// File: bench/rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props (
  input logic                    clk,
  input logic                    rst,
  input logic [rv_pkg::XLEN-1:0] pc,
  input logic                    halt,
  input logic                    retire_valid
);

  int fail_count = 0;

  no_retire_in_reset: assert property (@(posedge clk) rst |-> !retire_valid)
    else begin
      $error("retire_valid high while rst is high");
      fail_count++;
    end

  halt_low_after_reset: assert property (@(posedge clk) rst |=> !halt)
    else begin
      $error("halt high right after a reset cycle");
      fail_count++;
    end

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      $error("pc not 4-byte aligned");
      fail_count++;
    end

  // Halt is sticky and freezes the PC
  halt_freezes_pc: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt && $stable(pc))
    else begin
      $error("pc moved or halt dropped after halt");
      fail_count++;
    end

  halt_blocks_retire: assert property (@(posedge clk) disable iff (rst)
    halt |-> !retire_valid)
    else begin
      $error("retire_valid high while halted");
      fail_count++;
    end

endmodule

bind rv_core rv_core_props u_props (
  .clk(clk), .rst(rst), .pc(pc), .halt(halt), .retire_valid(retire_valid)
);

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  initial clk = 1'b0;

  always #5 clk = ~clk;  // 10 ns period

endmodule

// File: bench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int MAX_CYCLES = 400;
  localparam int MEM_WORDS  = 256;

  logic                  clk, rst, halt, retire_valid;
  logic [XLEN-1:0]       pc, insn, retire_data;
  logic [REG_ADDR_W-1:0] retire_rd;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] ref_regs [NUM_REGS];  // Reference register model
  logic [31:0] ref_pc, next_pc, exp_data;
  logic [4:0]  exp_rd;
  logic        ref_halt, next_halt, exp_valid;
  string       test_name;
  integer      seed;
  int          n, cycles;
  int          pc_errors, retire_errors, prop_errors, timeouts;

  tb_clock_gen u_clk (.clk(clk));

  rv_core dut (
    .clk(clk), .rst(rst), .pc(pc), .insn(insn), .halt(halt),
    .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
  );

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  // Expected ALU result straight from the RV32I rules
  function automatic logic [31:0] alu_expect(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, (a[31] != b[31]) ? a[31] : a < b};  // Negative one is less
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? (a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{a[31]}})
                          : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[n] = word;
    n++;
  endtask

  // LUI then ADDI; upper part rounds up when the low half is negative
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    emit({value[31:12] + 20'(value[11]), rd, OP_LUI});
    emit(enc_i(value[11:0], rd, 3'd0, rd, OP_REG_IMM));
  endtask

  task automatic emit_skip_slot();
    emit(enc_i(12'd1, 5'd12, 3'd0, 5'd12, OP_REG_IMM));  // Runs only if not jumped over
  endtask

  task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2);
    emit(enc_b(13'd8, rs2, rs1, f3));
    emit_skip_slot();
  endtask

  task automatic build_program();
    logic [31:0] r;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = enc_i(12'(i), 5'd0, 3'd0, 5'd20, OP_REG_IMM);
    end
    n = 0;
    for (int f = 0; f < 8; f++) begin
      load_reg(5'd1, $random(seed));
      load_reg(5'd2, $random(seed));
      r = $random(seed);
      emit(enc_i((f == 1 || f == 5) ? {7'd0, r[4:0]} : r[11:0], 5'd1, 3'(f), 5'd5,
                 OP_REG_IMM));
      emit(enc_r(7'd0, 5'd2, 5'd1, 3'(f), 5'd6, OP_REG_REG));
    end
    emit(enc_i({F7_ALT, r[9:5]}, 5'd1, F3_SRL_SRA, 5'd5, OP_REG_IMM));  // SRAI
    emit(enc_r(F7_ALT, 5'd2, 5'd1, F3_ADD_SUB, 5'd6, OP_REG_REG));
    emit(enc_r(F7_ALT, 5'd2, 5'd1, F3_SRL_SRA, 5'd7, OP_REG_REG));
    emit(enc_i(12'd5, 5'd1, 3'd0, 5'd0, OP_REG_IMM));       // Write to x0
    emit(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd7, OP_REG_REG));  // x0 + x0
    r = $random(seed);
    emit({r[31:12], 5'd8, OP_LUI});
    emit({r[19:0], 5'd9, OP_AUIPC});
    emit(enc_i(12'd1, 5'd1, 3'd0, 5'd4, OP_REG_IMM));     // x4 differs from x1
    emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd10, OP_REG_IMM));  // x10 = -1
    emit(enc_i(12'd1, 5'd0, 3'd0, 5'd11, OP_REG_IMM));    // x11 = 1
    // Taken form first, then not taken
    emit_branch(F3_BEQ, 5'd1, 5'd1);
    emit_branch(F3_BEQ, 5'd1, 5'd4);
    emit_branch(F3_BNE, 5'd1, 5'd4);
    emit_branch(F3_BNE, 5'd1, 5'd1);
    emit_branch(F3_BLT, 5'd10, 5'd11);
    emit_branch(F3_BLT, 5'd11, 5'd10);
    emit_branch(F3_BGE, 5'd11, 5'd10);
    emit_branch(F3_BGE, 5'd10, 5'd11);
    emit_branch(F3_BLTU, 5'd11, 5'd10);
    emit_branch(F3_BLTU, 5'd10, 5'd11);
    emit_branch(F3_BGEU, 5'd10, 5'd11);
    emit_branch(F3_BGEU, 5'd11, 5'd10);
    emit(enc_j(21'd8, 5'd13));
    emit_skip_slot();
    // JALR target is odd until bit 0 is cleared and lands past the skip slot
    load_reg(5'd15, 32'((n + 4) * 4 - 5));
    emit(enc_i(12'd6, 5'd15, F3_JALR, 5'd14, OP_JALR));
    emit_skip_slot();
    emit(enc_i(12'h0ff, 5'd0, F3_FENCE, 5'd0, OP_MISC_MEM));
    emit(32'h0000_007f);  // Undefined opcode
    emit(32'h0000_0073);  // ECALL
  endtask

  task automatic model_step(input logic [31:0] w);
    logic [31:0] a, b, imm_i, imm_b;
    logic [2:0]  f3;
    a         = ref_regs[w[19:15]];
    b         = ref_regs[w[24:20]];
    f3        = w[14:12];
    imm_i     = {{20{w[31]}}, w[31:20]};
    imm_b     = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    exp_valid = 1'b1;
    exp_rd    = w[11:7];
    exp_data  = 32'd0;
    next_pc   = ref_pc + 4;
    next_halt = ref_halt;
    if (ref_halt) begin
      test_name = "halted";
      exp_valid = 1'b0;
      next_pc   = ref_pc;
    end else begin
      case (w[6:0])
        OP_LUI: begin
          test_name = "lui";
          exp_data  = {w[31:12], 12'd0};
        end
        OP_AUIPC: begin
          test_name = "auipc";
          exp_data  = ref_pc + {w[31:12], 12'd0};
        end
        OP_REG_IMM: begin
          test_name = "reg_imm";
          exp_data  = alu_expect(f3, w[30] && f3 == 3'd5, a, imm_i);  // SRAI only
        end
        OP_REG_REG: begin
          test_name = "reg_reg";
          exp_data  = alu_expect(f3, w[30], a, b);
        end
        OP_BRANCH: begin
          test_name = "branch";
          exp_valid = 1'b0;
          case (f3)
            3'd0:    next_pc = (a == b) ? ref_pc + imm_b : next_pc;
            3'd1:    next_pc = (a != b) ? ref_pc + imm_b : next_pc;
            3'd4:    next_pc = ($signed(a) < $signed(b)) ? ref_pc + imm_b : next_pc;
            3'd5:    next_pc = ($signed(a) >= $signed(b)) ? ref_pc + imm_b : next_pc;
            3'd6:    next_pc = (a < b) ? ref_pc + imm_b : next_pc;
            default: next_pc = (a >= b) ? ref_pc + imm_b : next_pc;
          endcase
        end
        OP_JAL: begin
          test_name = "jal";
          exp_data  = ref_pc + 4;
          next_pc   = ref_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        OP_JALR: begin
          test_name = "jalr";
          exp_data  = ref_pc + 4;
          next_pc   = (a + imm_i) & ~32'd1;
        end
        OP_ENVIRON: begin
          test_name = "ecall";
          exp_valid = 1'b0;
          next_halt = 1'b1;
        end
        default: begin
          test_name = "no_write";  // FENCE and illegal words
          exp_valid = 1'b0;
        end
      endcase
    end
  endtask

  // Checks state, fetches on the falling edge and then checks the retire port
  task automatic step_cycle();
    assert (pc == ref_pc) else begin
      $display("** Error %s: pc expected %h, actual %h", test_name, ref_pc, pc);
      pc_errors++;
    end
    assert (halt == ref_halt) else begin
      $display("** Error %s: halt expected %b, actual %b", test_name, ref_halt, halt);
      pc_errors++;
    end
    insn = imem[pc[9:2]];
    #2;
    model_step(insn);
    assert (retire_valid == exp_valid && (!exp_valid || retire_rd == exp_rd)) else begin
      $display("** Error %s: retire valid/rd expected %b/%0d, actual %b/%0d", test_name,
               exp_valid, exp_rd, retire_valid, retire_rd);
      retire_errors++;
    end
    assert (!exp_valid || retire_data == exp_data) else begin
      $display("** Error %s: retire_data expected %h, actual %h", test_name, exp_data,
               retire_data);
      retire_errors++;
    end
    if (exp_valid && exp_rd != '0) begin
      ref_regs[exp_rd] = exp_data;
    end
    ref_pc   = next_pc;
    ref_halt = next_halt;
    @(negedge clk);
  endtask

  initial begin
    seed          = 47;
    rst           = 1'b1;
    insn          = enc_i(12'd0, 5'd0, 3'd0, 5'd0, OP_REG_IMM);  // NOP
    test_name     = "reset";
    pc_errors     = 0;
    retire_errors = 0;
    prop_errors   = 0;
    timeouts      = 0;
    ref_pc        = 32'd0;
    ref_halt      = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      ref_regs[i] = 32'd0;
    end
    build_program();

    repeat (8) begin
      @(negedge clk);
      assert (!halt && !retire_valid) else begin
        $display("** Error reset: halt/retire_valid expected 0/0, actual %b/%b", halt,
                 retire_valid);
        pc_errors++;
      end
    end
    rst = 1'b0;

    cycles = 0;
    while (!halt && cycles < MAX_CYCLES) begin
      step_cycle();
      cycles++;
    end
    if (!halt) begin
      $display("Timeout: the core never halted within %0d cycles", MAX_CYCLES);
      timeouts++;
    end
    repeat (4) step_cycle();  // Core must stay frozen

    prop_errors = dut.u_props.fail_count;
    $display("Error counts: pc/halt %0d, retire %0d, assertions %0d, timeouts %0d",
             pc_errors, retire_errors, prop_errors, timeouts);
    if (pc_errors + retire_errors + prop_errors + timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_rv_core -o sim_tb_rv_core

# Keep running past assertion errors so the testbench prints its summary
out=$(./obj_dir/sim_tb_rv_core +verilator+error+limit+1000 2>&1) || true
echo "$out"

if grep -qx "All tests passed" <<< "$out"; then
  exit 0
fi
exit 1

// File: sources.f
src/rv_pkg.sv
src/rv_alu.sv
src/rv_decode.sv
src/rv_pc_unit.sv
src/rv_regfile.sv
src/rv_core.sv
bench/rv_core_props.sv
bench/tb_clock_gen.sv
bench/tb_rv_core.sv

// File: src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_t         op,
  input  logic [rv_pkg::XLEN-1:0] a,
  input  logic [rv_pkg::XLEN-1:0] b,
  input  logic [2:0]              funct3,
  input  logic                    is_branch,
  output logic [rv_pkg::XLEN-1:0] result,
  output logic                    taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       cond;
  logic       invert;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;  // LUI
      default:    result = '0;
    endcase
  end

  // Branch condition
  // SUB selects the equality test and SLT or SLTU the less-than test
  always_comb begin
    case (op)
      ALU_SUB:  cond = (a == b);
      ALU_SLT:  cond = lt_signed;
      ALU_SLTU: cond = lt_unsigned;
      default:  cond = 1'b0;
    endcase
  end

  // Complemented forms of BEQ, BLT and BLTU
  assign invert = (funct3 == F3_BNE) || (funct3 == F3_BGE) || (funct3 == F3_BGEU);

  assign taken = is_branch && (cond ^ invert);

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                          clk,
  input  logic                          rst,
  output logic [rv_pkg::XLEN-1:0]       pc,
  input  logic [rv_pkg::XLEN-1:0]       insn,
  output logic                          halt,
  output logic                          retire_valid,
  output logic [rv_pkg::REG_ADDR_W-1:0] retire_rd,
  output logic [rv_pkg::XLEN-1:0]       retire_data
);
  import rv_pkg::*;

  rv_insn_t              insn_u;
  logic [REG_ADDR_W-1:0] rs1, rs2, rd;
  logic [XLEN-1:0]       imm;
  alu_op_t               alu_op;
  logic                  a_is_pc, b_is_imm, writes_rd;
  logic                  is_branch, is_jal, is_jalr, is_ecall, illegal;
  logic [XLEN-1:0]       rs1_data, rs2_data;
  logic [XLEN-1:0]       alu_a, alu_b, alu_result;
  logic                  taken;
  logic                  rf_we;
  logic [XLEN-1:0]       rf_wdata;

  assign insn_u = insn;

  rv_decode u_decode (
    .insn(insn_u), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .alu_op(alu_op),
    .a_is_pc(a_is_pc), .b_is_imm(b_is_imm), .writes_rd(writes_rd),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_ecall(is_ecall), .illegal(illegal)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst), .we(rf_we), .rd(rd), .rs1(rs1), .rs2(rs2),
    .wdata(rf_wdata), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  // Operand muxes
  assign alu_a = a_is_pc ? pc : rs1_data;  // AUIPC
  assign alu_b = b_is_imm ? imm : rs2_data;

  rv_alu u_alu (
    .op(alu_op), .a(alu_a), .b(alu_b), .funct3(insn_u.rtype.funct3),
    .is_branch(is_branch), .result(alu_result), .taken(taken)
  );

  rv_pc_unit u_pc (
    .clk(clk), .rst(rst), .is_branch(is_branch), .is_jal(is_jal),
    .is_jalr(is_jalr), .is_ecall(is_ecall), .taken(taken), .imm(imm),
    .alu_result(alu_result), .pc(pc), .halt(halt)
  );

  // Jumps link to the next sequential pc
  assign rf_wdata = (is_jal || is_jalr) ? pc + XLEN'(4) : alu_result;
  assign rf_we    = writes_rd && !illegal && !halt && !rst;

  // Retire port mirrors the register write
  assign retire_valid = rf_we;
  assign retire_rd    = rd;
  assign retire_data  = rf_wdata;

endmodule

// File: src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::rv_insn_t              insn,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  output logic [rv_pkg::REG_ADDR_W-1:0] rd,
  output logic [rv_pkg::XLEN-1:0]       imm,
  output rv_pkg::alu_op_t               alu_op,
  output logic                          a_is_pc,
  output logic                          b_is_imm,
  output logic                          writes_rd,
  output logic                          is_branch,
  output logic                          is_jal,
  output logic                          is_jalr,
  output logic                          is_ecall,
  output logic                          illegal
);
  import rv_pkg::*;

  logic [XLEN-1:0] imm_i, imm_b, imm_j, imm_u;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            f7_zero, f7_alt;
  logic            bad;

  // Shared funct3 to operation map; alt picks SUB or SRA
  function automatic alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  assign rs1    = insn.rtype.rs1;
  assign rs2    = insn.rtype.rs2;
  assign rd     = insn.rtype.rd;
  assign funct3 = insn.rtype.funct3;
  assign funct7 = insn.rtype.funct7;

  assign f7_zero = (funct7 == 7'd0);
  assign f7_alt  = (funct7 == F7_ALT);

  // Sign-extended immediates from the raw view
  assign imm_i = {{20{insn.raw[31]}}, insn.raw[31:20]};
  assign imm_b = {{20{insn.raw[31]}}, insn.raw[7], insn.raw[30:25], insn.raw[11:8], 1'b0};
  assign imm_j = {{12{insn.raw[31]}}, insn.raw[19:12], insn.raw[20], insn.raw[30:21], 1'b0};
  assign imm_u = {insn.raw[31:12], 12'd0};

  always_comb begin
    imm       = imm_i;
    alu_op    = ALU_ADD;
    a_is_pc   = 1'b0;
    b_is_imm  = 1'b0;
    writes_rd = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_ecall  = 1'b0;
    bad       = 1'b0;

    case (insn.rtype.opcode)
      OP_LUI: begin
        imm       = imm_u;
        alu_op    = ALU_PASS_B;
        b_is_imm  = 1'b1;
        writes_rd = 1'b1;
      end
      OP_AUIPC: begin
        imm       = imm_u;
        a_is_pc   = 1'b1;
        b_is_imm  = 1'b1;
        writes_rd = 1'b1;
      end
      OP_JAL: begin
        imm       = imm_j;
        is_jal    = 1'b1;
        writes_rd = 1'b1;  // Link value comes from the top level
      end
      OP_JALR: begin
        b_is_imm  = 1'b1;  // rs1 + imm gives the target
        is_jalr   = 1'b1;
        writes_rd = 1'b1;
        bad       = (funct3 != F3_JALR);
      end
      OP_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
        case (funct3)
          F3_BEQ, F3_BNE:   alu_op = ALU_SUB;
          F3_BLT, F3_BGE:   alu_op = ALU_SLT;
          F3_BLTU, F3_BGEU: alu_op = ALU_SLTU;
          default:          bad = 1'b1;
        endcase
      end
      OP_REG_IMM: begin
        b_is_imm  = 1'b1;
        writes_rd = 1'b1;
        alu_op    = f3_to_op(funct3, f7_alt && (funct3 == F3_SRL_SRA));
        if (funct3 == F3_SLL) begin
          bad = !f7_zero;
        end else if (funct3 == F3_SRL_SRA) begin
          bad = !(f7_zero || f7_alt);
        end
      end
      OP_REG_REG: begin
        writes_rd = 1'b1;
        alu_op    = f3_to_op(funct3, f7_alt);
        bad = !(f7_zero || (f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)));
      end
      OP_ENVIRON: begin
        is_ecall = (insn.raw[31:7] == '0);  // Only ECALL is supported, not EBREAK or CSRs
        bad      = !is_ecall;
      end
      OP_MISC_MEM: bad = (funct3 != F3_FENCE);  // FENCE is a no-op
      default:     bad = 1'b1;
    endcase

    illegal = bad;
    if (bad) begin
      writes_rd = 1'b0;
      is_branch = 1'b0;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
      is_ecall  = 1'b0;
    end
  end

endmodule

// File: src/rv_pc_unit.sv
`timescale 1ns/1ps

module rv_pc_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     is_branch,
  input  logic                     is_jal,
  input  logic                     is_jalr,
  input  logic                     is_ecall,
  input  logic                     taken,
  input  logic [rv_pkg::XLEN-1:0]  imm,
  input  logic [rv_pkg::XLEN-1:0]  alu_result,
  output logic [rv_pkg::XLEN-1:0]  pc,
  output logic                     halt
);
  import rv_pkg::*;

  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_target;  // pc-relative jump or branch target
  logic [XLEN-1:0] pc_next;

  assign pc_plus4  = pc + XLEN'(4);
  assign pc_target = pc + imm;

  always_comb begin
    if (halt) begin
      pc_next = pc;  // Frozen until reset
    end else if (is_jalr) begin
      pc_next = {alu_result[XLEN-1:1], 1'b0};
    end else if (is_jal || (is_branch && taken)) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= '0;
      halt <= 1'b0;
    end else begin
      pc <= pc_next;
      if (is_ecall) begin
        halt <= 1'b1;  // Sticky
      end
    end
  end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

  // Datapath and register file sizing
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int OPCODE_W   = 7;

  // Major opcodes, RV32I base encoding
  localparam logic [OPCODE_W-1:0] OP_LUI      = 7'b0110111;
  localparam logic [OPCODE_W-1:0] OP_AUIPC    = 7'b0010111;
  localparam logic [OPCODE_W-1:0] OP_JAL      = 7'b1101111;
  localparam logic [OPCODE_W-1:0] OP_JALR     = 7'b1100111;
  localparam logic [OPCODE_W-1:0] OP_BRANCH   = 7'b1100011;
  localparam logic [OPCODE_W-1:0] OP_REG_IMM  = 7'b0010011;
  localparam logic [OPCODE_W-1:0] OP_REG_REG  = 7'b0110011;
  localparam logic [OPCODE_W-1:0] OP_ENVIRON  = 7'b1110011;
  localparam logic [OPCODE_W-1:0] OP_MISC_MEM = 7'b0001111;

  // funct3 for the ALU groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Remaining single-encoding groups
  localparam logic [2:0] F3_JALR  = 3'b000;
  localparam logic [2:0] F3_FENCE = 3'b000;

  localparam logic [6:0] F7_ALT = 7'b0100000;  // SUB, SRA, SRAI

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // Instruction word seen as raw bits or as R-type fields
  // Immediates are scattered across fields and are built from raw
  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [OPCODE_W-1:0]   opcode;
    } rtype;
  } rv_insn_t;

endpackage

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  input  logic [rv_pkg::XLEN-1:0]       wdata,
  output logic [rv_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_pkg::XLEN-1:0]       rs2_data
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule
